/* design/enc_pkg.sv */
// Encoder constants and enums; count width and channel count are fixed, not parameters
package enc_pkg;

  // Position counter width, wraps modulo 2**16
  localparam int COUNT_W = 16;

  // Channels on the board
  localparam int NUM_CH = 2;

  // A/B phase as the bit pair {a, b}
  // Forward rotation walks 00 -> 01 -> 11 -> 10 -> 00
  typedef enum logic [1:0] {
    PH_00 = 2'b00,
    PH_01 = 2'b01,
    PH_11 = 2'b11,
    PH_10 = 2'b10
  } quad_phase_e;

  // Decoder outcome per clock
  typedef enum logic [1:0] {
    STEP_NONE  = 2'd0,  // Phase held
    STEP_UP    = 2'd1,  // One forward Gray step
    STEP_DOWN  = 2'd2,  // One reverse Gray step
    STEP_FAULT = 2'd3   // Both bits flipped, direction unknown
  } step_e;

endpackage

/* design/enc_wb_regs.sv */
// Wishbone classic slave; single-beat only, no byte selects, no err/rty, ack one clock after stb
`timescale 1ns/100ps

module enc_wb_regs import enc_pkg::*, wb_pkg::*; (
  input  logic               clk,
  input  logic               resetn,
  // Wishbone slave
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  logic [WB_AW-1:0]   wb_adr,
  input  logic [WB_DW-1:0]   wb_dat_w,
  output logic [WB_DW-1:0]   wb_dat_r,
  output logic               wb_ack,
  // Channel side
  input  logic [COUNT_W-1:0] count1,
  input  logic [COUNT_W-1:0] count2,
  input  logic               fault1,
  input  logic               fault2,
  output logic               clr1,
  output logic               clr2
);

  reg_addr_e         adr;
  logic              req;      // New cycle, not yet acked
  logic              ctrl_wr;  // Write to REG_CTRL this cycle
  logic [NUM_CH-1:0] status;
  logic [WB_DW-1:0]  rd_data;

  assign adr    = reg_addr_e'(wb_adr);
  assign req    = wb_cyc && wb_stb && !wb_ack;  // Ack masks the held request
  assign status = {fault2, fault1};

  // Read mux
  always_comb begin
    case (adr)
      REG_COUNT1: rd_data = WB_DW'(count1);  // Zero extend
      REG_COUNT2: rd_data = WB_DW'(count2);
      REG_STATUS: rd_data = WB_DW'(status);
      default:    rd_data = '0;              // CTRL is write-only
    endcase
  end

  // Clear pulses straight from the request, so counters clear on the ack edge
  assign ctrl_wr = req && wb_we && (adr == REG_CTRL);
  assign clr1    = ctrl_wr && wb_dat_w[CTRL_CLR1];
  assign clr2    = ctrl_wr && wb_dat_w[CTRL_CLR2];

  // Ack one clock after the request
  always_ff @(posedge clk) begin
    if (!resetn) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;  // Drops next clock, req is masked
    end
  end

  // Read data captured with ack, valid in the ack cycle
  always_ff @(posedge clk) begin
    if (req && !wb_we) begin
      wb_dat_r <= rd_data;
    end
  end

  // Host sees exactly one ack per request
  a_ack_single: assert property (@(posedge clk) disable iff (!resetn)
    wb_ack |=> !wb_ack)
    else $error("enc_wb_regs: ack high two cycles in a row");

  // No spurious ack
  a_ack_after_stb: assert property (@(posedge clk) disable iff (!resetn)
    wb_ack |-> $past(wb_stb))
    else $error("enc_wb_regs: ack without stb in prior cycle");

endmodule

/* design/quad_counter.sv */
// 16-bit position counter; wraps silently, clr beats a same-cycle step, fault is sticky
`timescale 1ns/100ps

module quad_counter import enc_pkg::*; (
  input  logic               clk,
  input  logic               resetn,
  input  logic               step_up,
  input  logic               step_down,
  input  logic               fault_evt,
  input  logic               clr,        // One-cycle clear from the register slave
  output logic [COUNT_W-1:0] count,
  output logic               fault       // Sticky until clr or reset
);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      count <= '0;
      fault <= 1'b0;
    end else if (clr) begin
      // Clear wins, a coincident step is dropped
      count <= '0;
      fault <= 1'b0;
    end else if (fault_evt) begin
      fault <= 1'b1;  // Count held, direction unknown
    end else if (step_up) begin
      count <= count + COUNT_W'(1);  // Wraps FFFF -> 0
    end else if (step_down) begin
      count <= count - COUNT_W'(1);  // Wraps 0 -> FFFF
    end
  end

endmodule

/* design/quad_decode.sv */
// Gray-code phase tracker; one step per clock at most, double-bit jumps flagged not counted
`timescale 1ns/100ps

module quad_decode import enc_pkg::*; (
  input  logic clk,
  input  logic resetn,
  input  logic a_sync,
  input  logic b_sync,
  output logic step_up,    // One-cycle pulse
  output logic step_down,  // One-cycle pulse
  output logic fault_evt   // One-cycle pulse on illegal jump
);

  quad_phase_e cur_ph;   // Phase seen this clock
  quad_phase_e prev_ph;  // Phase from last clock
  quad_phase_e up_ph;    // Expected phase for a forward step
  quad_phase_e dn_ph;    // Expected phase for a reverse step
  step_e       step;

  assign cur_ph = quad_phase_e'({a_sync, b_sync});

  // Neighbours of the previous phase
  always_comb begin
    case (prev_ph)
      PH_00: begin
        up_ph = PH_01;
        dn_ph = PH_10;
      end
      PH_01: begin
        up_ph = PH_11;
        dn_ph = PH_00;
      end
      PH_11: begin
        up_ph = PH_10;
        dn_ph = PH_01;
      end
      default: begin  // PH_10
        up_ph = PH_00;
        dn_ph = PH_11;
      end
    endcase
  end

  // Classify the transition
  always_comb begin
    if (cur_ph == prev_ph) begin
      step = STEP_NONE;
    end else if (cur_ph == up_ph) begin
      step = STEP_UP;
    end else if (cur_ph == dn_ph) begin
      step = STEP_DOWN;
    end else begin
      step = STEP_FAULT;  // Only the opposite corner is left
    end
  end

  always_ff @(posedge clk) begin
    prev_ph <= cur_ph;  // Also primes the phase during reset, so no step on release
    if (!resetn) begin
      step_up   <= 1'b0;
      step_down <= 1'b0;
      fault_evt <= 1'b0;
    end else begin
      step_up   <= (step == STEP_UP);
      step_down <= (step == STEP_DOWN);
      fault_evt <= (step == STEP_FAULT);
    end
  end

  // Counter relies on at most one request per clock
  a_step_excl: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0({step_up, step_down, fault_evt}))
    else $error("quad_decode: step_up/step_down/fault_evt overlap");

endmodule

/* design/quad_enc_top.sv */
// Two-channel quadrature encoder top; 4-clock pin-to-count latency, leds show count low nibbles
`timescale 1ns/100ps

module quad_enc_top import enc_pkg::*, wb_pkg::*; (
  input  logic             clk,
  input  logic             resetn,
  // Encoder pins, asynchronous
  input  logic             enc1a,
  input  logic             enc1b,
  input  logic             enc2a,
  input  logic             enc2b,
  // Wishbone slave
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [WB_AW-1:0] wb_adr,
  input  logic [WB_DW-1:0] wb_dat_w,
  output logic [WB_DW-1:0] wb_dat_r,
  output logic             wb_ack,
  // Board outputs
  output logic [7:0]       leds,
  output logic             faultn   // Low if either channel faulted
);

  // Per-channel nets, index 0 is channel 1
  logic [NUM_CH-1:0]  pin_a;
  logic [NUM_CH-1:0]  pin_b;
  logic [NUM_CH-1:0]  a_sync;
  logic [NUM_CH-1:0]  b_sync;
  logic [NUM_CH-1:0]  step_up;
  logic [NUM_CH-1:0]  step_down;
  logic [NUM_CH-1:0]  fault_evt;
  logic [NUM_CH-1:0]  clr;
  logic [NUM_CH-1:0]  fault;
  logic [COUNT_W-1:0] count [NUM_CH];

  assign pin_a = {enc2a, enc1a};
  assign pin_b = {enc2b, enc1b};

  // Channel pipelines: sync, decode, count
  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
    quad_sync u_sync (
      .clk(clk), .resetn(resetn), .a(pin_a[ch]), .b(pin_b[ch]),
      .a_sync(a_sync[ch]), .b_sync(b_sync[ch])
    );

    quad_decode u_decode (
      .clk(clk), .resetn(resetn), .a_sync(a_sync[ch]), .b_sync(b_sync[ch]),
      .step_up(step_up[ch]), .step_down(step_down[ch]), .fault_evt(fault_evt[ch])
    );

    quad_counter u_counter (
      .clk(clk), .resetn(resetn), .step_up(step_up[ch]), .step_down(step_down[ch]),
      .fault_evt(fault_evt[ch]), .clr(clr[ch]), .count(count[ch]), .fault(fault[ch])
    );
  end

  // Host register port
  enc_wb_regs u_regs (
    .clk(clk), .resetn(resetn),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .count1(count[0]), .count2(count[1]), .fault1(fault[0]), .fault2(fault[1]),
    .clr1(clr[0]), .clr2(clr[1])
  );

  assign leds   = {count[1][3:0], count[0][3:0]};  // Ch2 high nibble, ch1 low
  assign faultn = ~|fault;

endmodule

/* design/quad_sync.sv */
// Two-flop synchronizer for one A/B pair; pins must hold each level at least 2 clocks
`timescale 1ns/100ps

module quad_sync (
  input  logic clk,
  input  logic resetn,
  input  logic a,       // Async encoder pin A
  input  logic b,       // Async encoder pin B
  output logic a_sync,
  output logic b_sync
);

  // Shift chains, bit 0 is the metastable stage
  logic [1:0] a_ff;
  logic [1:0] b_ff;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      a_ff <= '0;
      b_ff <= '0;
    end else begin
      a_ff <= {a_ff[0], a};  // Shift in raw pin
      b_ff <= {b_ff[0], b};
    end
  end

  // Second stage feeds the decoder
  assign a_sync = a_ff[1];
  assign b_sync = b_ff[1];

endmodule

/* design/wb_pkg.sv */
// Wishbone register map; word addressed, no byte selects, CTRL bits are self-clearing
package wb_pkg;

  // Word address bits, four registers
  localparam int WB_AW = 2;

  // Data bus width
  localparam int WB_DW = 32;

  // Register map
  typedef enum logic [WB_AW-1:0] {
    REG_COUNT1 = 2'd0,  // RO, channel 1 count, zero extended
    REG_COUNT2 = 2'd1,  // RO, channel 2 count, zero extended
    REG_STATUS = 2'd2,  // RO, bit 0 ch1 fault, bit 1 ch2 fault
    REG_CTRL   = 2'd3   // WO clear bits, reads back 0
  } reg_addr_e;

  // Clear bits in REG_CTRL
  localparam int CTRL_CLR1 = 0;  // Clear channel 1 count and fault
  localparam int CTRL_CLR2 = 1;  // Clear channel 2 count and fault

endpackage

/* files.f */
design/enc_pkg.sv
design/wb_pkg.sv
design/quad_sync.sv
design/quad_decode.sv
design/quad_counter.sv
design/enc_wb_regs.sv
design/quad_enc_top.sv
verif/tb_quad_enc.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the quadrature encoder testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  -f files.f --top-module tb_quad_enc -o tb_quad_enc

./obj_dir/tb_quad_enc > sim.log 2>&1 || true
cat sim.log

# Result decided by the log
if grep -q "^TB PASSED$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* verif/tb_quad_enc.sv */
// Self-checking testbench; each pin phase held 6 clocks, register reads only after counts settle
`timescale 1ns/100ps

module tb_quad_enc
  import enc_pkg::*, wb_pkg::*;
();

  localparam int unsigned SEED        = 32'hc2c0bc27;
  localparam int          ACK_TIMEOUT = 20;  // Clocks to wait for wb_ack
  localparam int          HOLD_CLKS   = 6;   // Clocks per pin phase
  localparam int          SETTLE_CLKS = 4;   // Pin to count latency

  // Forward rotation order of {a, b}
  localparam logic [1:0] FWD_SEQ [4] = '{2'b00, 2'b01, 2'b11, 2'b10};

  logic             clk;
  logic             resetn;
  logic             enc1a;
  logic             enc1b;
  logic             enc2a;
  logic             enc2b;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [WB_AW-1:0] wb_adr;
  logic [WB_DW-1:0] wb_dat_w;
  logic [WB_DW-1:0] wb_dat_r;
  logic             wb_ack;
  logic [7:0]       leds;
  logic             faultn;

  // Reference model state, index 0 is channel 1
  logic [COUNT_W-1:0] m_count [NUM_CH];
  logic               m_fault [NUM_CH];
  logic [1:0]         pin_ph  [NUM_CH];  // Phase currently on the pins
  bit                 settled;           // DUT count should match the model

  int val_errs;  // Register read mismatches
  int mon_errs;  // leds / faultn mismatches
  int tmo_errs;  // Handshake timeouts

  quad_enc_top uut (
    .clk(clk), .resetn(resetn),
    .enc1a(enc1a), .enc1b(enc1b), .enc2a(enc2a), .enc2b(enc2b),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .leds(leds), .faultn(faultn)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  // Rising edge plus drive skew
  task automatic tick();
    @(posedge clk);
    #10;
  endtask

  // Compare and report, caller keeps the count
  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp, output bit bad);
    bad = (got !== exp);
    if (bad) begin
      $display("ERR %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Index of a phase in the forward order
  function automatic int gray_pos(logic [1:0] ph);
    int pos;
    pos = 0;
    for (int i = 0; i < 4; i++) begin
      if (FWD_SEQ[i] == ph) pos = i;
    end
    return pos;
  endfunction

  // One phase change applied to {fault, count}
  function automatic logic [COUNT_W:0] ref_step(logic [1:0] old_ph, logic [1:0] new_ph,
                                               logic [COUNT_W:0] st);
    int                 delta;
    logic [COUNT_W-1:0] cnt;
    logic               flt;
    delta = (gray_pos(new_ph) - gray_pos(old_ph) + 4) % 4;
    cnt   = st[COUNT_W-1:0];
    flt   = st[COUNT_W];
    if (delta == 2) begin
      flt = 1'b1;  // Opposite corner, count held
    end else if (delta == 1) begin
      cnt = cnt + COUNT_W'(1);
    end else if (delta == 3) begin
      cnt = cnt - COUNT_W'(1);
    end
    return {flt, cnt};
  endfunction

  // Drive a new phase on one channel, update the model, hold
  task automatic set_phase(int ch, logic [1:0] ph);
    logic [COUNT_W:0] st;
    st          = ref_step(pin_ph[ch], ph, {m_fault[ch], m_count[ch]});
    m_fault[ch] = st[COUNT_W];
    m_count[ch] = st[COUNT_W-1:0];
    pin_ph[ch]  = ph;
    settled     = 1'b0;  // DUT lags by the pipeline
    if (ch == 0) begin
      enc1a = ph[1];
      enc1b = ph[0];
    end else begin
      enc2a = ph[1];
      enc2b = ph[0];
    end
    repeat (SETTLE_CLKS) tick();
    settled = 1'b1;
    repeat (HOLD_CLKS - SETTLE_CLKS) tick();
  endtask

  // Legal Gray step forward or back
  task automatic move_step(int ch, bit up);
    int pos;
    pos = (gray_pos(pin_ph[ch]) + (up ? 1 : 3)) % 4;
    set_phase(ch, FWD_SEQ[pos]);
  endtask

  // Returns in the ack cycle, or after the timeout
  task automatic wait_ack();
    int n;
    n = 0;
    tick();
    while (!wb_ack && n < ACK_TIMEOUT) begin
      tick();
      n++;
    end
    if (!wb_ack) begin
      $display("Wishbone ack did not arrive within %0d clocks", ACK_TIMEOUT);
      tmo_errs++;
    end
  endtask

  task automatic wb_write(logic [WB_AW-1:0] adr, logic [WB_DW-1:0] data);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_ack();
    wb_cyc = 1'b0;  // Release after ack
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    tick();         // One idle clock between cycles
  endtask

  task automatic wb_read(logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] data);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack();
    data   = wb_dat_r;  // Valid in the ack cycle
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    tick();
  endtask

  task automatic read_expect(string name, logic [WB_AW-1:0] adr, logic [WB_DW-1:0] exp);
    logic [WB_DW-1:0] data;
    bit               bad;
    wb_read(adr, data);
    check_value(name, data, exp, bad);
    if (bad) val_errs++;
  endtask

  // Both counts and status against the model
  task automatic check_regs();
    read_expect("count1", REG_COUNT1, WB_DW'(m_count[0]));
    read_expect("count2", REG_COUNT2, WB_DW'(m_count[1]));
    read_expect("status", REG_STATUS, WB_DW'({m_fault[1], m_fault[0]}));
  endtask

  // CTRL write; model cleared while the monitor is paused
  task automatic clear_channels(logic [WB_DW-1:0] mask);
    settled = 1'b0;
    wb_write(REG_CTRL, mask);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (mask[ch]) begin
        m_count[ch] = '0;
        m_fault[ch] = 1'b0;
      end
    end
    settled = 1'b1;
  endtask

  // Board outputs vs model, sampled mid-cycle
  always @(negedge clk) begin
    bit bad_l;
    bit bad_f;
    if (settled) begin
      check_value("leds", 32'(leds), 32'({m_count[1][3:0], m_count[0][3:0]}), bad_l);
      check_value("faultn", 32'(faultn), 32'(!(m_fault[0] || m_fault[1])), bad_f);
      mon_errs += int'(bad_l) + int'(bad_f);
    end
  end

  initial begin
    int unsigned seed_ret;
    int          n1;
    int          n2;
    int          ch;
    bit          up;
    bit          bad;
    seed_ret = $urandom(SEED);  // Seed once
    resetn   = 1'b0;
    enc1a    = 1'b0;
    enc1b    = 1'b0;
    enc2a    = 1'b0;
    enc2b    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    settled  = 1'b0;
    val_errs = 0;
    mon_errs = 0;
    tmo_errs = 0;
    for (int i = 0; i < NUM_CH; i++) begin
      m_count[i] = '0;
      m_fault[i] = 1'b0;
      pin_ph[i]  = 2'b00;
    end
    repeat (8) @(posedge clk);  // Reset for 8 cycles
    #10;
    resetn  = 1'b1;
    settled = 1'b1;

    // Idle state after reset
    check_value("wb_ack", 32'(wb_ack), 32'h0, bad);
    if (bad) val_errs++;
    check_regs();

    // Forward steps, random count per channel
    n1 = int'($urandom_range(24, 5));
    n2 = int'($urandom_range(24, 5));
    repeat (n1) move_step(0, 1'b1);
    repeat (n2) move_step(1, 1'b1);
    check_regs();

    // Clear both, then reverse through zero
    clear_channels((WB_DW'(1) << CTRL_CLR1) | (WB_DW'(1) << CTRL_CLR2));
    check_regs();
    n1 = int'($urandom_range(20, 3));
    n2 = int'($urandom_range(20, 3));
    repeat (n1) move_step(0, 1'b0);
    repeat (n2) move_step(1, 1'b0);
    check_regs();

    // Random walk on both channels
    repeat (16) begin
      ch = int'($urandom_range(1, 0));
      up = 1'($urandom_range(1, 0));
      move_step(ch, up);
    end
    check_regs();

    // Both bits of channel 2 at once
    set_phase(1, pin_ph[1] ^ 2'b11);
    check_regs();
    repeat (6) begin
      up = 1'($urandom_range(1, 0));
      move_step(1, up);  // Still counts, fault sticks
    end
    check_regs();

    // Clear channel 2 only
    clear_channels(WB_DW'(1) << CTRL_CLR2);
    check_regs();
    read_expect("ctrl", REG_CTRL, WB_DW'(0));  // Write-only
    repeat (3) move_step(1, 1'b1);
    check_regs();

    $display("Errors: %0d read, %0d monitor, %0d timeout", val_errs, mon_errs, tmo_errs);
    if (val_errs + mon_errs + tmo_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
